// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - files:
      - src/rv_isa_pkg.sv
      - src/rv_core_pkg.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_execute.sv
      - src/rv_lsu.sv
      - src/rv_core.sv
  - target: test
    files:
      - verification/rv_core_tb.sv

// ==== src.f ====
+incdir+src
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_lsu.sv
src/rv_core.sv
verification/rv_core_tb.sv

// ==== src/rv_core.sv ====
`include "rv_defs.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   arst_n,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic [`XLEN-1:0]       imem_rdata,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic                   halted
);
  import rv_core_pkg::*;

  logic [`XLEN-1:0]  pc;
  logic [`XLEN-1:0]  pc_plus4;
  logic [`XLEN-1:0]  next_pc;
  ctrl_t             ctrl;
  logic [`REG_AW-1:0] rs1_addr;
  logic [`REG_AW-1:0] rs2_addr;
  logic [`REG_AW-1:0] rd_addr;
  logic [`XLEN-1:0]  imm;
  logic [`XLEN-1:0]  rs1_val;
  logic [`XLEN-1:0]  rs2_val;
  logic [`XLEN-1:0]  result;
  logic [`XLEN-1:0]  load_val;
  logic [`XLEN-1:0]  wb_val;
  dmem_req_t         lsu_req;
  logic              run;   // this instruction retires normally
  logic              mem_en;

  assign run       = !halted && !ctrl.halt;  // pc stays on the ebreak
  assign imem_addr = pc;
  assign pc_plus4  = pc + `XLEN'd4;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else begin
      if (run) pc <= next_pc;
      if (ctrl.halt) halted <= 1'b1;  // sticky until reset
    end
  end

  rv_decoder i_rv_decoder (
    .inst     (imem_rdata),
    .ctrl     (ctrl),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm      (imm)
  );

  rv_regfile i_rv_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (ctrl.reg_we && run),
    .waddr  (rd_addr),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .wdata  (wb_val),
    .rdata1 (rs1_val),
    .rdata2 (rs2_val)
  );

  rv_execute i_rv_execute (
    .ctrl    (ctrl),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .imm     (imm),
    .result  (result),
    .next_pc (next_pc)
  );

  rv_lsu i_rv_lsu (
    .ctrl       (ctrl),
    .addr       (result),
    .store_val  (rs2_val),
    .dmem_req   (lsu_req),
    .dmem_rdata (dmem_rdata),
    .load_val   (load_val)
  );

  // no memory traffic in reset or once halted
  assign mem_en = arst_n && !halted;

  always_comb begin
    dmem_req    = lsu_req;
    dmem_req.we = lsu_req.we && mem_en;
    dmem_req.re = lsu_req.re && mem_en;
  end

  always_comb begin
    unique case (ctrl.wb_src)
      wb_link: wb_val = pc_plus4;
      wb_load: wb_val = load_val;
      default: wb_val = result;
    endcase
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// ==== src/rv_core_pkg.sv ====
`include "rv_defs.svh"

package rv_core_pkg;

  // source of the value written to rd
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_link = 2'd1,  // pc + 4 for jal / jalr
    wb_load = 2'd2
  } wb_src_e;

  // decoded control word, one per instruction
  typedef struct packed {
    logic                   a_sel_pc;   // operand a is pc, else rs1
    logic                   b_sel_imm;  // operand b is imm, else rs2
    logic                   sub;
    logic                   is_branch;
    rv_isa_pkg::branch_f3_e br_cond;
    logic                   is_jump;    // jal and jalr
    logic                   reg_we;
    wb_src_e                wb_src;
    logic                   load;
    logic                   store;
    rv_isa_pkg::mem_size_e  size;
    logic                   halt;       // ebreak
  } ctrl_t;

  // data memory request, memory answers within the same cycle
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic             we;
    logic [3:0]       strb;
    logic [`XLEN-1:0] wdata;
    logic             re;
  } dmem_req_t;

endpackage

// ==== src/rv_decoder.sv ====
`include "rv_defs.svh"

module rv_decoder (
  input  logic [`XLEN-1:0]   inst,
  output rv_core_pkg::ctrl_t ctrl,
  output logic [`REG_AW-1:0] rs1_addr,
  output logic [`REG_AW-1:0] rs2_addr,
  output logic [`REG_AW-1:0] rd_addr,
  output logic [`XLEN-1:0]   imm
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];

  // all immediates sign-extend from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // lui reads x0 so the adder yields 0 + imm
  assign rs1_addr = (opcode == op_lui) ? '0 : inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  always_comb begin
    ctrl         = '0;  // nop: no write, no memory access
    ctrl.wb_src  = wb_alu;
    ctrl.br_cond = branch_f3_e'(funct3);
    ctrl.size    = mem_size_e'(funct3);
    imm          = imm_i;
    unique case (opcode)
      op_lui: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        imm            = imm_u;
      end
      op_auipc: begin
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_we    = 1'b1;
        imm            = imm_u;
      end
      op_jal: begin
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.reg_we    = 1'b1;
        ctrl.wb_src    = wb_link;
        imm            = imm_j;
      end
      op_jalr: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.reg_we    = 1'b1;
        ctrl.wb_src    = wb_link;
      end
      op_branch: begin  // adder forms the target, compare is separate
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      op_load: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.load      = 1'b1;
        ctrl.reg_we    = 1'b1;
        ctrl.wb_src    = wb_load;
      end
      op_store: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.store     = 1'b1;
        imm            = imm_s;
      end
      op_imm: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.reg_we    = (funct3 == 3'b000);  // addi only
      end
      op_reg: begin
        ctrl.sub    = inst[30];
        ctrl.reg_we = (funct3 == 3'b000);  // add / sub only
      end
      op_system: ctrl.halt = inst[20];  // ebreak, ecall falls through as nop
      default: ;
    endcase
  end

endmodule

// ==== src/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define XLEN 32

// integer register file size
`define REG_COUNT 32
`define REG_AW    5   // enough bits to address REG_COUNT entries

// first fetch address after reset
`define RESET_PC 32'h8000_0000

`endif

// ==== src/rv_execute.sv ====
`include "rv_defs.svh"

module rv_execute (
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   rs1_val,
  input  logic [`XLEN-1:0]   rs2_val,
  input  logic [`XLEN-1:0]   imm,
  output logic [`XLEN-1:0]   result,
  output logic [`XLEN-1:0]   next_pc
);
  import rv_isa_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] op_b_inv;
  logic             eq;
  logic             lt;
  logic             ltu;
  logic             taken;

  assign op_a = ctrl.a_sel_pc  ? pc  : rs1_val;
  assign op_b = ctrl.b_sel_imm ? imm : rs2_val;

  // subtract as a + ~b + 1
  assign op_b_inv = op_b ^ {`XLEN{ctrl.sub}};
  assign result   = op_a + op_b_inv + {{(`XLEN-1){1'b0}}, ctrl.sub};

  // branch compares always look at the register values
  assign eq  = (rs1_val == rs2_val);
  assign lt  = ($signed(rs1_val) < $signed(rs2_val));
  assign ltu = (rs1_val < rs2_val);

  always_comb begin
    unique case (ctrl.br_cond)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl.is_jump) begin
      next_pc = {result[`XLEN-1:1], 1'b0};  // jal target is even already
    end else if (ctrl.is_branch && taken) begin
      next_pc = result;                     // pc + imm_b
    end else begin
      next_pc = pc + `XLEN'd4;
    end
  end

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    op_lui    = 7'b011_0111,
    op_auipc  = 7'b001_0111,
    op_jal    = 7'b110_1111,
    op_jalr   = 7'b110_0111,
    op_branch = 7'b110_0011,
    op_load   = 7'b000_0011,
    op_store  = 7'b010_0011,
    op_imm    = 7'b001_0011,  // only addi is decoded
    op_reg    = 7'b011_0011,  // only add and sub
    op_system = 7'b111_0011
  } opcode_e;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    f3_beq  = 3'b000,
    f3_bne  = 3'b001,
    f3_blt  = 3'b100,
    f3_bge  = 3'b101,
    f3_bltu = 3'b110,
    f3_bgeu = 3'b111
  } branch_f3_e;

  // funct3 of loads and stores, the u variants exist for loads only
  typedef enum logic [2:0] {
    sz_b  = 3'b000,
    sz_h  = 3'b001,
    sz_w  = 3'b010,
    sz_bu = 3'b100,
    sz_hu = 3'b101
  } mem_size_e;

endpackage

// ==== src/rv_lsu.sv ====
`include "rv_defs.svh"

module rv_lsu (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  logic [`XLEN-1:0]       addr,
  input  logic [`XLEN-1:0]       store_val,
  output rv_core_pkg::dmem_req_t dmem_req,
  input  logic [`XLEN-1:0]       dmem_rdata,
  output logic [`XLEN-1:0]       load_val
);
  import rv_isa_pkg::*;

  logic [1:0]       offset;
  logic [`XLEN-1:0] lane;

  assign offset = addr[1:0];

  assign dmem_req.addr = addr;
  assign dmem_req.we   = ctrl.store;
  assign dmem_req.re   = ctrl.load;

  // store lanes, byte and half replicated across the word
  always_comb begin
    unique case (ctrl.size)
      sz_b: begin
        dmem_req.strb  = 4'b0001 << offset;
        dmem_req.wdata = {4{store_val[7:0]}};
      end
      sz_h: begin
        dmem_req.strb  = 4'b0011 << offset;
        dmem_req.wdata = {2{store_val[15:0]}};
      end
      sz_w: begin
        dmem_req.strb  = 4'b1111;
        dmem_req.wdata = store_val;
      end
      default: begin
        dmem_req.strb  = 4'b0000;
        dmem_req.wdata = store_val;
      end
    endcase
  end

  // shift the addressed lane down to bit 0
  assign lane = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    unique case (ctrl.size)
      sz_b:    load_val = {{24{lane[7]}}, lane[7:0]};
      sz_bu:   load_val = {24'h000000, lane[7:0]};
      sz_h:    load_val = {{16{lane[15]}}, lane[15:0]};
      sz_hu:   load_val = {16'h0000, lane[15:0]};
      sz_w:    load_val = dmem_rdata;
      default: load_val = '0;
    endcase
  end

  // misaligned halves and words are not supported
  always_comb begin
    if ((ctrl.load || ctrl.store) && ctrl.size inside {sz_h, sz_hu}) begin
      a_half_aligned: assert final (offset[0] == 1'b0);
    end
    if ((ctrl.load || ctrl.store) && ctrl.size == sz_w) begin
      a_word_aligned: assert final (offset == 2'b00);
    end
  end

endmodule

// ==== src/rv_regfile.sv ====
`include "rv_defs.svh"

module rv_regfile (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               we,
  input  logic [`REG_AW-1:0] waddr,
  input  logic [`REG_AW-1:0] raddr1,
  input  logic [`REG_AW-1:0] raddr2,
  input  logic [`XLEN-1:0]   wdata,
  output logic [`XLEN-1:0]   rdata1,
  output logic [`XLEN-1:0]   rdata2
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // combinational reads
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== verification/rv_core_tb.sv ====
`include "rv_defs.svh"

module rv_core_tb;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic             clk;
  logic             arst_n;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_rdata;
  dmem_req_t        dmem_req;
  logic [`XLEN-1:0] dmem_rdata;
  logic             halted;

  logic [31:0] imem [256];
  logic [31:0] dmem [512];  // byte addresses 0 .. 0x7ff
  logic [31:0] prog [$];

  // shadow state of the reference model
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic [31:0] m_dmem [512];
  logic        m_halted;
  logic        exp_store;
  logic        exp_load;
  logic [31:0] exp_addr;
  logic [3:0]  exp_strb;
  logic [31:0] exp_wdata;

  logic [31:0] lfsr_state = 32'd5826;
  logic        running = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          n_tests = 0;
  int          cycles = 0;
  int          test_len_total = 0;
  int          slot;

  rv_core i_rv_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 32'hD000_0001;
      r = {r[30:0], lsb};
    end
    return r;
  endfunction

  function automatic logic [31:0] imem_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `RESET_PC;
    return imem[off[9:2]];
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // instruction encoders, one per format
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};  // base is always x0
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic void emit(input logic [31:0] w);
    prog.push_back(w);
  endfunction

  function automatic void load_imm(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;  // round so addi can add a negative low part
    emit(enc_u(hi[19:0], rd, op_lui));
    emit(enc_i(v[11:0], rd, 3'b000, rd, op_imm));
  endfunction

  // architectural model of one instruction
  function automatic void iss_step(input logic [31:0] inst);
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [31:0] addr, word, wv, npc;
    logic [7:0]  byt;
    logic [15:0] half;
    logic        wr, taken;
    int          i;
    exp_store = 1'b0;
    exp_load  = 1'b0;
    if (m_halted) return;
    a     = m_regs[inst[19:15]];
    b     = m_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'h000};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    npc   = m_pc + 32'd4;
    wr    = 1'b0;
    wv    = '0;
    case (inst[6:0])
      op_lui: begin
        wv = imm_u;
        wr = 1'b1;
      end
      op_auipc: begin
        wv = m_pc + imm_u;
        wr = 1'b1;
      end
      op_jal: begin
        wv  = m_pc + 32'd4;
        wr  = 1'b1;
        npc = m_pc + imm_j;
      end
      op_jalr: begin
        wv  = m_pc + 32'd4;
        wr  = 1'b1;
        npc = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        case (inst[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) npc = m_pc + imm_b;
      end
      op_load: begin
        addr = a + imm_i;
        word = m_dmem[addr[10:2]];
        byt  = word[addr[1:0] * 8 +: 8];
        half = word[addr[1] * 16 +: 16];
        case (inst[14:12])
          3'b000:  wv = {{24{byt[7]}}, byt};
          3'b100:  wv = {24'h0, byt};
          3'b001:  wv = {{16{half[15]}}, half};
          3'b101:  wv = {16'h0, half};
          default: wv = word;
        endcase
        wr       = 1'b1;
        exp_load = 1'b1;
        exp_addr = addr;
      end
      op_store: begin
        addr = a + imm_s;
        case (inst[14:12])
          3'b000:  exp_strb = 4'b0001 << addr[1:0];
          3'b001:  exp_strb = 4'b0011 << addr[1:0];
          default: exp_strb = 4'b1111;
        endcase
        exp_store = 1'b1;
        exp_addr  = addr;
        exp_wdata = b << (addr[1:0] * 8);  // value moved into its lanes
        for (i = 0; i < 4; i++) begin
          if (exp_strb[i]) m_dmem[addr[10:2]][i*8 +: 8] = exp_wdata[i*8 +: 8];
        end
      end
      op_imm: begin
        wv = a + imm_i;
        wr = (inst[14:12] == 3'b000);
      end
      op_reg: begin
        wv = inst[30] ? a - b : a + b;
        wr = (inst[14:12] == 3'b000);
      end
      op_system: begin
        if (inst[31:20] == 12'h001) begin  // ebreak
          m_halted = 1'b1;
          npc      = m_pc;
        end
      end
      default: ;
    endcase
    if (wr && inst[11:7] != 5'd0) m_regs[inst[11:7]] = wv;
    m_pc = npc;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // instruction and read data arrive after the core has settled
  always @(posedge clk) begin
    #5;
    imem_rdata = imem_word(imem_addr);
    #5;
    dmem_rdata = dmem[dmem_req.addr[10:2]];
  end

  // store commit on the rising edge
  always @(posedge clk) begin
    if (dmem_req.we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.strb[i]) dmem[dmem_req.addr[10:2]][i*8 +: 8] = dmem_req.wdata[i*8 +: 8];
      end
    end
  end

  // compare against the model mid-cycle, then advance the model
  always @(negedge clk) begin
    if (running) begin
      check_val("imem_addr", m_pc, imem_addr);
      check_val("halted", 32'(m_halted), 32'(halted));
      iss_step(imem_word(m_pc));
      check_val("dmem_req.we", 32'(exp_store), 32'(dmem_req.we));
      check_val("dmem_req.re", 32'(exp_load), 32'(dmem_req.re));
      if (exp_store || exp_load) begin
        check_val("dmem_req.addr", exp_addr, dmem_req.addr);
      end
      if (exp_store) begin
        check_val("dmem_req.strb", 32'(exp_strb), 32'(dmem_req.strb));
        check_val("dmem_req.wdata", exp_wdata & lane_mask(exp_strb),
                  dmem_req.wdata & lane_mask(exp_strb));
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (test_len_total > 0 && cycles > 4 * test_len_total) begin
      $display("ERROR: simulation timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic run_program(input string name);
    int          err0, chk0;
    logic [31:0] held;
    err0    = errors;
    chk0    = checks;
    running = 1'b0;
    foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
    test_len_total += prog.size() + 13;  // plus reset and halt hold
    n_tests++;
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    m_pc     = `RESET_PC;
    m_halted = 1'b0;
    foreach (m_regs[i]) m_regs[i] = '0;
    m_dmem   = dmem;
    arst_n   = 1'b1;
    running  = 1'b1;
    while (halted !== 1'b1) @(negedge clk);
    held = imem_addr;
    repeat (10) @(negedge clk);
    check_val("imem_addr after halt", held, imem_addr);
    $display("%-8s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  task automatic load_and_keep(input logic [2:0] f3, input logic [11:0] addr);
    emit(enc_i(addr, 5'd0, f3, 5'd3, op_load));
    emit(enc_s(12'h400 + 12'(4 * slot), 5'd3, sz_w));
    slot++;
  endtask

  initial begin
    logic [31:0] va [4];
    logic [31:0] vb [4];
    logic [31:0] rnd;
    branch_f3_e  c;
    int          t, r, k, o;
    arst_n     = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    foreach (dmem[i]) dmem[i] = rand_bits(32);

    prog.delete();  // lui, auipc, addi, add, sub
    for (t = 0; t < 4; t++) begin
      load_imm(5'd1, rand_bits(32));
      load_imm(5'd2, rand_bits(32));
      emit(enc_r(7'h00, 5'd2, 5'd1, 5'd3));
      emit(enc_r(7'h20, 5'd2, 5'd1, 5'd4));
      rnd = rand_bits(12);
      emit(enc_i(rnd[11:0], 5'd1, 3'b000, 5'd5, op_imm));
      rnd = rand_bits(20);
      emit(enc_u(rnd[19:0], 5'd6, op_auipc));
      for (r = 1; r <= 6; r++) emit(enc_s(12'h100 + 12'(32 * t + 4 * r), 5'(r), sz_w));
    end
    emit(ebreak_word);
    run_program("alu");

    prog.delete();  // equal, random and sign-crossing pairs
    va = '{rand_bits(32), 32'h5, 32'h8000_0000, 32'h1};
    vb = '{rand_bits(32), 32'h5, 32'h1, 32'h8000_0000};
    for (t = 0; t < 4; t++) begin
      load_imm(5'd1, va[t]);
      load_imm(5'd2, vb[t]);
      emit(enc_i(12'd0, 5'd0, 3'b000, 5'd10, op_imm));
      c = c.first();
      for (k = 0; k < c.num(); k++) begin
        emit(enc_b(13'd8, 5'd2, 5'd1, c));  // taken skips the increment
        emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
        c = c.next();
      end
      emit(enc_s(12'h700 + 12'(4 * t), 5'd10, sz_w));
    end
    emit(ebreak_word);
    run_program("branch");

    prog.delete();
    emit(enc_j(21'd12, 5'd1));
    emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
    emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
    emit(enc_s(12'h200, 5'd1, sz_w));
    emit(enc_u(20'd0, 5'd5, op_auipc));
    emit(enc_i(12'd13, 5'd5, 3'b000, 5'd2, op_jalr));  // odd offset, bit 0 dropped
    emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
    emit(enc_s(12'h204, 5'd2, sz_w));
    emit(enc_s(12'h208, 5'd10, sz_w));
    emit(ebreak_word);
    run_program("jump");

    prog.delete();
    slot = 0;
    for (t = 0; t < 2; t++) begin
      for (o = 0; o < 4; o++) begin
        load_and_keep(sz_b, 12'h300 + 12'(4 * t + o));
        load_and_keep(sz_bu, 12'h300 + 12'(4 * t + o));
        if (o % 2 == 0) begin
          load_and_keep(sz_h, 12'h300 + 12'(4 * t + o));
          load_and_keep(sz_hu, 12'h300 + 12'(4 * t + o));
        end
        if (o == 0) load_and_keep(sz_w, 12'h300 + 12'(4 * t));
      end
    end
    emit(ebreak_word);
    run_program("load");

    prog.delete();
    load_imm(5'd1, rand_bits(32));
    for (o = 0; o < 4; o++) emit(enc_s(12'h500 + 12'(o), 5'd1, sz_b));
    emit(enc_s(12'h510, 5'd1, sz_h));
    emit(enc_s(12'h512, 5'd1, sz_h));
    emit(enc_s(12'h520, 5'd1, sz_w));
    emit(ebreak_word);
    run_program("store");

    prog.delete();
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, op_imm));
    emit(enc_s(12'h600, 5'd1, sz_w));
    emit(ebreak_word);
    emit(enc_s(12'h604, 5'd1, sz_w));  // never reached
    run_program("ebreak");

    running = 1'b0;
    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
